/* vlog.f */
+incdir+test
common/fetch_pkg.sv
common/predict_pkg.sv
rtl/fetch_pc_gen.sv
fetch_align/fetch_align.sv
branch_predictor/branch_predictor.sv
rtl/fetch_top.sv
test/tb_fetch_top.sv

/* test/fetch_ref_model.svh */
`ifndef FETCH_REF_MODEL_SVH
`define FETCH_REF_MODEL_SVH

// halfword memory image that wraps at the end
localparam int MEM_HALVES = 4096;

logic [15:0]       imem [MEM_HALVES];

// copy of the predictor table with the full upper address as tag
logic              mdl_valid  [PRED_ENTRIES];
logic [ADDR_W-1:0] mdl_tag    [PRED_ENTRIES];
logic [ADDR_W-1:0] mdl_target [PRED_ENTRIES];
logic [CTR_W-1:0]  mdl_ctr    [PRED_ENTRIES];

function automatic logic [15:0] half_at(input logic [ADDR_W-1:0] addr);
   return imem[(addr >> 1) % MEM_HALVES];
endfunction

function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] addr);
   return {half_at(addr + 2), half_at(addr)};
endfunction

function automatic logic rvc_at(input logic [ADDR_W-1:0] pc);
   logic [15:0] lo;
   lo = half_at(pc);
   return lo[1:0] != 2'b11;
endfunction

// compressed instructions come out zero-extended
function automatic logic [INSTR_W-1:0] instr_at(input logic [ADDR_W-1:0] pc);
   if (rvc_at(pc)) begin
      return {16'h0000, half_at(pc)};
   end
   return {half_at(pc + 2), half_at(pc)};
endfunction

function automatic int table_index(input logic [ADDR_W-1:0] pc);
   return int'(pc[PRED_IDX_W:1]);
endfunction

function automatic logic entry_hits(input logic [ADDR_W-1:0] pc);
   return mdl_valid[table_index(pc)] && (mdl_tag[table_index(pc)] == (pc >> (PRED_IDX_W + 1)));
endfunction

function automatic logic predicts_taken(input logic [ADDR_W-1:0] pc);
   return entry_hits(pc) && (mdl_ctr[table_index(pc)] >= CTR_TAKEN_MIN);
endfunction

task automatic clear_table();
   for (int i = 0; i < PRED_ENTRIES; i++) begin
      mdl_valid[i]  = 1'b0;
      mdl_tag[i]    = '0;
      mdl_target[i] = '0;
      mdl_ctr[i]    = CTR_INIT;
   end
endtask

task automatic train_table(input logic [ADDR_W-1:0] pc, input logic [ADDR_W-1:0] target,
                           input logic taken);
   int idx;
   idx = table_index(pc);
   if (taken && entry_hits(pc)) begin
      mdl_target[idx] = target;
      if (mdl_ctr[idx] != {CTR_W{1'b1}}) begin
         mdl_ctr[idx] = mdl_ctr[idx] + 1'b1;
      end
   end
   else if (taken) begin
      // a miss replaces the entry
      mdl_valid[idx]  = 1'b1;
      mdl_tag[idx]    = pc >> (PRED_IDX_W + 1);
      mdl_target[idx] = target;
      mdl_ctr[idx]    = CTR_INIT;
   end
   else if (entry_hits(pc) && mdl_ctr[idx] != '0) begin
      mdl_ctr[idx] = mdl_ctr[idx] - 1'b1;
   end
endtask

`endif

/* test/tb_fetch_top.sv */
`timescale 1ns/100ps

module tb_fetch_top
   import fetch_pkg::*;
   import predict_pkg::*;
();

   localparam int SEED         = 65149;
   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 16;
   localparam int DRIVE_DLY    = 2;
   localparam int N_INSTR      = 3000;
   localparam int IDLE_LIMIT   = 200;

   logic               clk_i;
   logic               rstn_i;
   logic               imem_rsp_i;
   logic [WORD_W-1:0]  imem_rdata_i;
   logic               imem_req_o;
   logic [ADDR_W-1:0]  imem_addr_o;
   logic               resolve_i;
   logic [ADDR_W-1:0]  resolve_pc_i;
   logic [ADDR_W-1:0]  resolve_target_i;
   logic               resolve_taken_i;
   logic               resolve_mispredict_i;
   logic               dec_valid_o;
   logic [INSTR_W-1:0] dec_instr_o;
   logic [ADDR_W-1:0]  dec_pc_o;
   logic               dec_rvc_o;
   logic               dec_pred_taken_o;

   `include "fetch_ref_model.svh"

   // requests waiting for their answer in issue order
   logic [ADDR_W-1:0]  req_addr_q [$];
   int                 req_due_q [$];
   logic [ADDR_W-1:0]  recent_pc_q [$];

   int                 cyc;
   int                 last_due;
   int                 issued;
   int                 received;
   int                 emitted;
   int                 idle;
   int                 checks;
   int                 errors;
   bit                 timed_out;
   logic [ADDR_W-1:0]  exp_pc;
   logic [ADDR_W-1:0]  exp_fetch;

   fetch_top fetch_top_inst (
      .clk_i                ( clk_i ),
      .rstn_i               ( rstn_i ),
      .imem_rsp_i           ( imem_rsp_i ),
      .imem_rdata_i         ( imem_rdata_i ),
      .imem_req_o           ( imem_req_o ),
      .imem_addr_o          ( imem_addr_o ),
      .resolve_i            ( resolve_i ),
      .resolve_pc_i         ( resolve_pc_i ),
      .resolve_target_i     ( resolve_target_i ),
      .resolve_taken_i      ( resolve_taken_i ),
      .resolve_mispredict_i ( resolve_mispredict_i ),
      .dec_valid_o          ( dec_valid_o ),
      .dec_instr_o          ( dec_instr_o ),
      .dec_pc_o             ( dec_pc_o ),
      .dec_rvc_o            ( dec_rvc_o ),
      .dec_pred_taken_o     ( dec_pred_taken_o )
   );

   initial begin
      clk_i = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk_i = ~clk_i;
      end
   end

   task automatic compare_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   // roughly half the halfwords are compressed
   task automatic fill_memory();
      logic [15:0] h;
      for (int i = 0; i < MEM_HALVES; i++) begin
         h = 16'($urandom);
         if ($urandom % 2 == 0) begin
            h[1:0] = 2'b11;
         end
         else begin
            h[1:0] = 2'($urandom % 3);
         end
         imem[i] = h;
      end
   endtask

   task automatic drive_inputs();
      imem_rsp_i   = 1'b0;
      imem_rdata_i = $urandom;
      if (req_due_q.size() > 0 && req_due_q[0] <= cyc) begin
         imem_rsp_i   = 1'b1;
         imem_rdata_i = word_at(req_addr_q.pop_front());
         void'(req_due_q.pop_front());
         received++;
      end
      resolve_i            = 1'b0;
      resolve_taken_i      = 1'b0;
      resolve_mispredict_i = 1'b0;
      resolve_pc_i         = $urandom;
      resolve_target_i     = $urandom;
      // resolves only name addresses that were emitted recently
      if (recent_pc_q.size() > 0 && $urandom % 4 == 0) begin
         resolve_i            = 1'b1;
         resolve_pc_i         = recent_pc_q[$urandom % recent_pc_q.size()];
         resolve_taken_i      = $urandom % 2;
         resolve_target_i     = ($urandom % MEM_HALVES) * 2;
         resolve_mispredict_i = ($urandom % 8 == 0);
      end
   endtask

   task automatic check_cycle();
      logic              mispredict;
      logic              exp_pred;
      logic [ADDR_W-1:0] pred_tgt;
      logic [ADDR_W-1:0] redirect_pc;
      int                lat;
      mispredict = resolve_i && resolve_mispredict_i;
      exp_pred   = dec_valid_o && predicts_taken(exp_pc);
      pred_tgt   = mdl_target[table_index(exp_pc)];
      compare_value("dec_pred_taken_o", exp_pred, dec_pred_taken_o);
      if (dec_valid_o) begin
         compare_value("dec_pc_o", exp_pc, dec_pc_o);
         compare_value("dec_instr_o", instr_at(exp_pc), dec_instr_o);
         compare_value("dec_rvc_o", rvc_at(exp_pc), dec_rvc_o);
         emitted++;
         idle = 0;
         recent_pc_q.push_back(exp_pc);
         if (recent_pc_q.size() > 8) begin
            void'(recent_pc_q.pop_front());
         end
         exp_pc = exp_pred ? pred_tgt : exp_pc + (rvc_at(exp_pc) ? ADDR_W'(2) : ADDR_W'(4));
      end
      else begin
         idle++;
      end
      // mispredict wins over a prediction in the same cycle
      redirect_pc = mispredict ? resolve_target_i : pred_tgt;
      if (mispredict) begin
         exp_pc = resolve_target_i;
      end
      if (mispredict || exp_pred) begin
         compare_value("imem_req_o in redirect cycle", 0, imem_req_o);
      end
      if (imem_req_o) begin
         compare_value("imem_addr_o", exp_fetch, imem_addr_o);
         exp_fetch = exp_fetch + ADDR_W'(4);
         lat       = 1 + $urandom % 4;
         last_due  = (cyc + lat > last_due) ? cyc + lat : last_due + 1;
         req_addr_q.push_back(imem_addr_o);
         req_due_q.push_back(last_due);
         issued++;
      end
      if (mispredict || exp_pred) begin
         exp_fetch = {redirect_pc[ADDR_W-1:2], 2'b00};
      end
      compare_value("outstanding words", 1, (issued - received) <= MAX_CREDITS);
      if (resolve_i) begin
         train_table(resolve_pc_i, resolve_target_i, resolve_taken_i);
      end
   endtask

   initial begin
      void'($urandom(SEED));
      rstn_i               = 1'b0;
      imem_rsp_i           = 1'b0;
      imem_rdata_i         = '0;
      resolve_i            = 1'b0;
      resolve_pc_i         = '0;
      resolve_target_i     = '0;
      resolve_taken_i      = 1'b0;
      resolve_mispredict_i = 1'b0;
      cyc       = 0;
      last_due  = 0;
      issued    = 0;
      received  = 0;
      emitted   = 0;
      idle      = 0;
      checks    = 0;
      errors    = 0;
      timed_out = 1'b0;
      exp_pc    = RESET_PC;
      exp_fetch = RESET_PC;
      fill_memory();
      clear_table();

      // reset cycles and the first cycle after release with all strobes quiet
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(posedge clk_i);
         #DRIVE_DLY;
         if (i == RESET_CYCLES - 1) begin
            rstn_i = 1'b1;
         end
         @(negedge clk_i);
         compare_value("imem_req_o in reset", 0, imem_req_o);
         compare_value("dec_valid_o in reset", 0, dec_valid_o);
         compare_value("dec_pred_taken_o in reset", 0, dec_pred_taken_o);
      end

      while (emitted < N_INSTR && !timed_out) begin
         @(posedge clk_i);
         #DRIVE_DLY;
         cyc++;
         drive_inputs();
         @(negedge clk_i);
         check_cycle();
         if (idle > IDLE_LIMIT) begin
            timed_out = 1'b1;
            errors++;
            $display("no instruction was emitted within %0d cycles, giving up", IDLE_LIMIT);
         end
      end

      $display("instructions %0d, checks %0d, errors %0d", emitted, checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end
      else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* rtl/fetch_top.sv */
`timescale 1ns/100ps

module fetch_top
   import fetch_pkg::*;
(
   input  logic               clk_i,
   input  logic               rstn_i,

   // instruction memory
   input  logic               imem_rsp_i,
   input  logic [WORD_W-1:0]  imem_rdata_i,
   output logic               imem_req_o,
   output logic [ADDR_W-1:0]  imem_addr_o,

   // resolve stage
   input  logic               resolve_i,
   input  logic [ADDR_W-1:0]  resolve_pc_i,
   input  logic [ADDR_W-1:0]  resolve_target_i,
   input  logic               resolve_taken_i,
   input  logic               resolve_mispredict_i,

   // decode
   output logic               dec_valid_o,
   output logic [INSTR_W-1:0] dec_instr_o,
   output logic [ADDR_W-1:0]  dec_pc_o,
   output logic               dec_rvc_o,
   output logic               dec_pred_taken_o
);

   logic              credit_ok;
   logic [ADDR_W-1:0] pred_target;
   logic              redirect;
   logic [ADDR_W-1:0] redirect_pc;

   fetch_pc_gen fetch_pc_gen_inst (
      .clk_i                ( clk_i ),
      .rstn_i               ( rstn_i ),
      .credit_ok_i          ( credit_ok ),
      .pred_taken_i         ( dec_pred_taken_o ),
      .pred_target_i        ( pred_target ),
      .dec_valid_i          ( dec_valid_o ),
      .resolve_i            ( resolve_i ),
      .resolve_mispredict_i ( resolve_mispredict_i ),
      .resolve_target_i     ( resolve_target_i ),
      .imem_req_o           ( imem_req_o ),
      .imem_addr_o          ( imem_addr_o ),
      .redirect_o           ( redirect ),
      .redirect_pc_o        ( redirect_pc )
   );

   fetch_align fetch_align_inst (
      .clk_i         ( clk_i ),
      .rstn_i        ( rstn_i ),
      .imem_req_i    ( imem_req_o ),
      .imem_rsp_i    ( imem_rsp_i ),
      .imem_rdata_i  ( imem_rdata_i ),
      .redirect_i    ( redirect ),
      .redirect_pc_i ( redirect_pc ),
      .credit_ok_o   ( credit_ok ),
      .dec_valid_o   ( dec_valid_o ),
      .dec_instr_o   ( dec_instr_o ),
      .dec_pc_o      ( dec_pc_o ),
      .dec_rvc_o     ( dec_rvc_o )
   );

   // lookup runs on the registered decode output
   branch_predictor branch_predictor_inst (
      .clk_i            ( clk_i ),
      .rstn_i           ( rstn_i ),
      .lookup_valid_i   ( dec_valid_o ),
      .lookup_pc_i      ( dec_pc_o ),
      .resolve_i        ( resolve_i ),
      .resolve_pc_i     ( resolve_pc_i ),
      .resolve_target_i ( resolve_target_i ),
      .resolve_taken_i  ( resolve_taken_i ),
      .pred_taken_o     ( dec_pred_taken_o ),
      .pred_target_o    ( pred_target )
   );

endmodule

/* branch_predictor/branch_predictor.sv */
`timescale 1ns/100ps

module branch_predictor
   import fetch_pkg::*;
   import predict_pkg::*;
(
   input  logic              clk_i,
   input  logic              rstn_i,

   // lookup on the decode output
   input  logic              lookup_valid_i,
   input  logic [ADDR_W-1:0] lookup_pc_i,

   // training from resolve
   input  logic              resolve_i,
   input  logic [ADDR_W-1:0] resolve_pc_i,
   input  logic [ADDR_W-1:0] resolve_target_i,
   input  logic              resolve_taken_i,

   output logic              pred_taken_o,
   output logic [ADDR_W-1:0] pred_target_o
);

   logic                  valid_q  [PRED_ENTRIES];
   logic [PRED_TAG_W-1:0] tag_q    [PRED_ENTRIES];
   logic [ADDR_W-1:0]     target_q [PRED_ENTRIES];
   logic [CTR_W-1:0]      ctr_q    [PRED_ENTRIES];

   logic [PRED_IDX_W-1:0] lk_idx;
   logic [PRED_TAG_W-1:0] lk_tag;
   logic                  lk_hit;

   logic [PRED_IDX_W-1:0] rs_idx;
   logic [PRED_TAG_W-1:0] rs_tag;
   logic                  rs_hit;
   logic [CTR_W-1:0]      rs_ctr;

   // halfword granular index
   assign lk_idx = lookup_pc_i[PRED_IDX_W:1];
   assign lk_tag = lookup_pc_i[ADDR_W-1:PRED_IDX_W+1];
   assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

   assign pred_taken_o  = lookup_valid_i && lk_hit && (ctr_q[lk_idx] >= CTR_TAKEN_MIN);
   assign pred_target_o = target_q[lk_idx];

   assign rs_idx = resolve_pc_i[PRED_IDX_W:1];
   assign rs_tag = resolve_pc_i[ADDR_W-1:PRED_IDX_W+1];
   assign rs_hit = valid_q[rs_idx] && (tag_q[rs_idx] == rs_tag);
   assign rs_ctr = ctr_q[rs_idx];

   // valid bits and counters
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int i = 0; i < PRED_ENTRIES; i++) begin
            valid_q[i] <= 1'b0;
            ctr_q[i]   <= CTR_INIT;
         end
      end
      else if (resolve_i) begin
         if (resolve_taken_i) begin
            if (!rs_hit) begin
               // allocate, replacing whatever was there
               valid_q[rs_idx] <= 1'b1;
               ctr_q[rs_idx]   <= CTR_INIT;
            end
            else if (rs_ctr != CTR_MAX) begin
               ctr_q[rs_idx] <= rs_ctr + 1'b1;
            end
         end
         else if (rs_hit && rs_ctr != '0) begin
            ctr_q[rs_idx] <= rs_ctr - 1'b1;
         end
      end
   end

   // tag and target, written on every taken resolve
   always_ff @(posedge clk_i) begin
      if (resolve_i && resolve_taken_i) begin
         tag_q[rs_idx]    <= rs_tag;
         target_q[rs_idx] <= resolve_target_i;
      end
   end

endmodule

/* fetch_align/fetch_align.sv */
`timescale 1ns/100ps

module fetch_align
   import fetch_pkg::*;
(
   input  logic               clk_i,
   input  logic               rstn_i,

   // memory side
   input  logic               imem_req_i,
   input  logic               imem_rsp_i,
   input  logic [WORD_W-1:0]  imem_rdata_i,

   // redirect from the pc generator
   input  logic               redirect_i,
   input  logic [ADDR_W-1:0]  redirect_pc_i,

   output logic               credit_ok_o,

   // decode side
   output logic               dec_valid_o,
   output logic [INSTR_W-1:0] dec_instr_o,
   output logic [ADDR_W-1:0]  dec_pc_o,
   output logic               dec_rvc_o
);

   // outstanding requests and the stale part of them
   logic [CREDIT_W-1:0] inflight_q, inflight_d;
   logic [CREDIT_W-1:0] discard_q, discard_d;

   // two-word response queue
   logic [WORD_W-1:0]   queue_q [2];
   logic                wr_ptr_q;
   logic                rd_ptr_q;
   logic [CREDIT_W-1:0] q_count_q, q_count_d;
   logic                q_empty;
   logic                push;
   logic                pop;

   logic [WORD_W-1:0]   head;
   logic [HALF_W-1:0]   head_lo;
   logic [HALF_W-1:0]   head_hi;
   logic                head_lo_rvc;
   logic                hold_rvc;

   align_state_e        state_q, state_d;
   logic [HALF_W-1:0]   hold_q, hold_d;
   logic [ADDR_W-1:0]   pc_q, pc_d;
   logic                skip_q, skip_d;
   logic                live_q;

   logic                emit;
   logic [INSTR_W-1:0]  emit_instr;
   logic                emit_rvc;

   assign q_empty     = (q_count_q == '0);
   assign head        = queue_q[rd_ptr_q];
   assign head_lo     = head[HALF_W-1:0];
   assign head_hi     = head[WORD_W-1:HALF_W];
   assign head_lo_rvc = (head_lo[1:0] != 2'b11);
   assign hold_rvc    = (hold_q[1:0] != 2'b11);

   // held off for one cycle after reset
   assign credit_ok_o = live_q && (int'(inflight_q) + int'(q_count_q) < MAX_CREDITS);

   // stale responses are dropped before they reach the queue
   assign push = imem_rsp_i && (discard_q == '0) && !redirect_i;

   always_comb begin
      inflight_d = inflight_q;
      if (imem_req_i && !imem_rsp_i) begin
         inflight_d = inflight_q + 1'b1;
      end
      else if (!imem_req_i && imem_rsp_i) begin
         inflight_d = inflight_q - 1'b1;
      end

      discard_d = discard_q;
      if (imem_rsp_i && discard_q != '0) begin
         discard_d = discard_q - 1'b1;
      end
      // everything still out belongs to the old path
      if (redirect_i) begin
         discard_d = imem_rsp_i ? inflight_q - 1'b1 : inflight_q;
      end
   end

   // instruction selection, one per cycle at most
   always_comb begin
      state_d    = state_q;
      hold_d     = hold_q;
      pc_d       = pc_q;
      skip_d     = skip_q;
      pop        = 1'b0;
      emit       = 1'b0;
      emit_instr = '0;
      emit_rvc   = 1'b0;

      if (state_q == ALIGN_HALF) begin
         if (hold_rvc) begin
            emit       = 1'b1;
            emit_instr = INSTR_W'(hold_q);
            emit_rvc   = 1'b1;
            pc_d       = pc_q + ADDR_W'(2);
            state_d    = ALIGN_EMPTY;
         end
         else if (!q_empty) begin
            // 32-bit instruction straddling two words
            pop        = 1'b1;
            emit       = 1'b1;
            emit_instr = {head_lo, hold_q};
            pc_d       = pc_q + ADDR_W'(4);
            hold_d     = head_hi;
         end
      end
      else if (!q_empty) begin
         pop = 1'b1;
         if (skip_q) begin
            // target sits in the upper half
            hold_d  = head_hi;
            state_d = ALIGN_HALF;
            skip_d  = 1'b0;
         end
         else if (head_lo_rvc) begin
            emit       = 1'b1;
            emit_instr = INSTR_W'(head_lo);
            emit_rvc   = 1'b1;
            pc_d       = pc_q + ADDR_W'(2);
            hold_d     = head_hi;
            state_d    = ALIGN_HALF;
         end
         else begin
            emit       = 1'b1;
            emit_instr = head;
            pc_d       = pc_q + ADDR_W'(4);
         end
      end

      if (redirect_i) begin
         pop     = 1'b0;
         emit    = 1'b0;
         state_d = ALIGN_EMPTY;
         pc_d    = redirect_pc_i;
         skip_d  = redirect_pc_i[1];
      end
   end

   always_comb begin
      q_count_d = q_count_q;
      if (push && !pop) begin
         q_count_d = q_count_q + 1'b1;
      end
      else if (!push && pop) begin
         q_count_d = q_count_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         live_q      <= 1'b0;
         inflight_q  <= '0;
         discard_q   <= '0;
         wr_ptr_q    <= 1'b0;
         rd_ptr_q    <= 1'b0;
         q_count_q   <= '0;
         state_q     <= ALIGN_EMPTY;
         pc_q        <= RESET_PC;
         skip_q      <= 1'b0;
         dec_valid_o <= 1'b0;
      end
      else begin
         live_q      <= 1'b1;
         inflight_q  <= inflight_d;
         discard_q   <= discard_d;
         state_q     <= state_d;
         pc_q        <= pc_d;
         skip_q      <= skip_d;
         dec_valid_o <= emit;
         if (redirect_i) begin
            wr_ptr_q  <= 1'b0;
            rd_ptr_q  <= 1'b0;
            q_count_q <= '0;
         end
         else begin
            wr_ptr_q  <= wr_ptr_q ^ push;
            rd_ptr_q  <= rd_ptr_q ^ pop;
            q_count_q <= q_count_d;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         queue_q[wr_ptr_q] <= imem_rdata_i;
      end
      hold_q      <= hold_d;
      dec_instr_o <= emit_instr;
      dec_pc_o    <= pc_q;
      dec_rvc_o   <= emit_rvc;
   end

endmodule

/* rtl/fetch_pc_gen.sv */
`timescale 1ns/100ps

module fetch_pc_gen
   import fetch_pkg::*;
(
   input  logic              clk_i,
   input  logic              rstn_i,

   // credit level from the aligner
   input  logic              credit_ok_i,

   // prediction on the current decode output
   input  logic              pred_taken_i,
   input  logic [ADDR_W-1:0] pred_target_i,
   input  logic              dec_valid_i,

   // correction from the resolve stage
   input  logic              resolve_i,
   input  logic              resolve_mispredict_i,
   input  logic [ADDR_W-1:0] resolve_target_i,

   // memory request
   output logic              imem_req_o,
   output logic [ADDR_W-1:0] imem_addr_o,

   // redirect broadcast
   output logic              redirect_o,
   output logic [ADDR_W-1:0] redirect_pc_o
);

   logic [ADDR_W-1:0] fetch_addr_q;
   logic [ADDR_W-1:0] redirect_word;
   logic              mispredict;
   logic              predicted;

   // a mispredict overrides any prediction in the same cycle
   assign mispredict = resolve_i && resolve_mispredict_i;
   assign predicted  = dec_valid_i && pred_taken_i;

   assign redirect_o    = mispredict || predicted;
   assign redirect_pc_o = mispredict ? resolve_target_i : pred_target_i;

   // fetch restarts at the word holding the target
   assign redirect_word = {redirect_pc_o[ADDR_W-1:2], 2'b00};

   // no request in a redirect cycle, the address is about to change
   assign imem_req_o  = credit_ok_i && !redirect_o;
   assign imem_addr_o = fetch_addr_q;

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         fetch_addr_q <= RESET_PC;
      end
      else if (redirect_o) begin
         fetch_addr_q <= redirect_word;
      end
      else if (imem_req_o) begin
         fetch_addr_q <= fetch_addr_q + ADDR_W'(4);
      end
   end

endmodule

/* common/predict_pkg.sv */
package predict_pkg;

   import fetch_pkg::*;

   // direct-mapped table geometry
   localparam int PRED_ENTRIES = 16;
   localparam int PRED_IDX_W   = 4;

   // index from pc[4:1], tag is everything above it
   localparam int PRED_TAG_W = ADDR_W - PRED_IDX_W - 1;

   // 2-bit saturating counter
   localparam int CTR_W = 2;

   // weakly taken on reset and on allocation
   localparam logic [CTR_W-1:0] CTR_INIT      = 2'd2;
   localparam logic [CTR_W-1:0] CTR_TAKEN_MIN = 2'd2;
   localparam logic [CTR_W-1:0] CTR_MAX       = 2'd3;

endpackage

/* common/fetch_pkg.sv */
package fetch_pkg;

   // datapath widths
   localparam int ADDR_W  = 32;
   localparam int WORD_W  = 32;
   localparam int INSTR_W = 32;
   localparam int HALF_W  = WORD_W / 2;

   // first fetch after reset, word aligned
   localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0100;

   // words requested but not yet consumed by the aligner
   localparam int MAX_CREDITS = 2;

   // counter width for in-flight and queued words
   localparam int CREDIT_W = $clog2(MAX_CREDITS + 1);

   // alignment state
   // ALIGN_EMPTY: nothing held
   // ALIGN_HALF: upper halfword of the previous word is held
   typedef enum logic {
      ALIGN_EMPTY = 1'b0,
      ALIGN_HALF  = 1'b1
   } align_state_e;

endpackage
